//--- Makefile
# Verilator build and run of the sd card reader testbench

SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_sdcard
FILELIST  = verilog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# the simulation binary exits non-zero on $fatal, so make fails with it
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- src/sd_clk_gen.sv
// card clock divider
// half period of 2**clock_divider clk cycles, one-cycle edge strobes
`timescale 1ns/100ps
`default_nettype none

module sd_clk_gen #(
  parameter int unsigned clock_divider = 2
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  enable,
  output logic sclk,
  output logic rise,
  output logic fall
);

  logic [clock_divider-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt  <= '0;
      sclk <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end else if (!enable) begin
      // parked, clock held low and the next edge is a rise
      cnt  <= '0;
      sclk <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end else begin
      cnt  <= cnt + 1'b1;
      rise <= 1'b0;
      fall <= 1'b0;
      if (cnt == '1) begin
        sclk <= !sclk;
        // strobe is high in the cycle after the pin edge
        rise <= !sclk;
        fall <= sclk;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sd_host_pkg.sv
// sd host package
// user side opcodes, card type codes and sector geometry
`default_nettype none

package sd_host_pkg;

  // command port opcodes, sampled every cycle as plain levels
  typedef enum logic [1:0] {
    cmd_idle        = 2'd0,
    cmd_read_sector = 2'd1,
    cmd_next_byte   = 2'd2
  } host_cmd_e;

  // card type as found by bring-up
  typedef enum logic [1:0] {
    card_unknown = 2'd0,
    card_sdv1    = 2'd1,
    card_sdv2    = 2'd2,
    card_sdhc    = 2'd3
  } card_type_e;

  // one sector, held whole in the buffer
  localparam int sector_bytes = 512;
  // sector number width as given by the user
  localparam int sector_addr_w = 32;
  // buffer index width, log2 of sector_bytes
  localparam int byte_index_w = 9;

endpackage

`default_nettype wire

//--- src/sd_proto_pkg.sv
// sd protocol package
// command indices, tokens, reader states and spi engine operations
`default_nettype none

package sd_proto_pkg;

  // command index field of a frame
  typedef enum logic [5:0] {
    go_idle      = 6'd0,
    send_if_cond = 6'd8,
    read_single  = 6'd17,
    app_op_cond  = 6'd41,
    app_cmd      = 6'd55,
    read_ocr     = 6'd58
  } sd_cmd_e;

  // engine operations
  typedef enum logic [1:0] {
    op_wake     = 2'd0,   // 80 clocks, mosi high
    op_cmd      = 2'd1,   // frame then r1
    op_cmd_long = 2'd2,   // frame then r1 and 4 more bytes
    op_rx_byte  = 2'd3    // single byte
  } spi_op_e;

  // reader FSM, also shown on card_stat
  typedef enum logic [3:0] {
    st_wake   = 4'd0,
    st_cmd0   = 4'd1,
    st_cmd8   = 4'd2,
    st_cmd55  = 4'd3,
    st_acmd41 = 4'd4,
    st_cmd58  = 4'd5,
    st_ready  = 4'd6,
    st_cmd17  = 4'd7,
    st_token  = 4'd8,
    st_data   = 4'd9,
    st_crc    = 4'd10,
    st_error  = 4'd11
  } reader_state_e;

  localparam logic [7:0] sd_start_token = 8'hFE;
  // voltage range 2.7-3.6V plus check pattern 0xAA
  localparam logic [31:0] sd_if_cond_arg = 32'h0000_01AA;
  // host supports high capacity
  localparam logic [31:0] sd_hcs_arg = 32'h4000_0000;
  localparam int resp_timeout_bytes = 16;

endpackage

`default_nettype wire

//--- src/sd_read_if.sv
// sector read interface
// read requests from the host and the sector byte stream back
`timescale 1ns/100ps
`default_nettype none

interface sd_read_if;
  import sd_host_pkg::*;

  // request, rsector valid with the rstart pulse
  logic                     rstart;
  logic [sector_addr_w-1:0] rsector;
  // status and data stream
  logic                     rbusy;
  logic                     rdone;
  logic                     outen;
  logic [byte_index_w-1:0]  outaddr;
  logic [7:0]               outbyte;

  modport reader (input rstart, rsector,
                  output rbusy, rdone, outen, outaddr, outbyte);

  modport host (output rstart, rsector,
                input rbusy, rdone, outen, outaddr, outbyte);

endinterface

`default_nettype wire

//--- src/sd_reader.sv
// sd card reader
// SDv2/SDHC bring-up, then single sector reads streamed out byte by byte
`timescale 1ns/100ps
`default_nettype none

module sd_reader #(
  parameter int unsigned clock_divider = 2
) (
  input  wire                       clk,
  input  wire                       rst_n,
  sd_read_if.reader                 host,
  output wire                       sd_clk,
  output wire                       sd_mosi,
  input  wire                       sd_miso,
  output wire  [3:0]                card_stat,
  output sd_host_pkg::card_type_e   card_type
);
  import sd_host_pkg::*;
  import sd_proto_pkg::*;

  reader_state_e           state;
  logic                    pending;
  logic [31:0]             cmd_arg;
  // token poll count, then data address, then crc byte count
  logic [byte_index_w-1:0] cnt;

  sd_spi_if spi ();

  sd_spi_engine #(.clock_divider(clock_divider)) i_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (spi),
    .sd_clk  (sd_clk),
    .sd_mosi (sd_mosi),
    .sd_miso (sd_miso)
  );

  assign card_stat  = state;
  // busy through bring-up, each read and a failed card
  assign host.rbusy = (state != st_ready);

  // operation for the current state
  always_comb begin
    spi.op    = op_rx_byte;
    spi.index = go_idle;
    spi.arg   = '0;
    case (state)
      st_wake:  spi.op = op_wake;
      st_cmd0:  spi.op = op_cmd;
      st_cmd8: begin
        spi.op    = op_cmd_long;
        spi.index = send_if_cond;
        spi.arg   = sd_if_cond_arg;
      end
      st_cmd55: begin
        spi.op    = op_cmd;
        spi.index = app_cmd;
      end
      st_acmd41: begin
        spi.op    = op_cmd;
        spi.index = app_op_cond;
        spi.arg   = sd_hcs_arg;
      end
      st_cmd58: begin
        spi.op    = op_cmd_long;
        spi.index = read_ocr;
      end
      st_cmd17: begin
        spi.op    = op_cmd;
        spi.index = read_single;
        spi.arg   = cmd_arg;
      end
      default: spi.op = op_rx_byte;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_wake;
      pending    <= 1'b0;
      cnt        <= '0;
      card_type  <= card_unknown;
      spi.start  <= 1'b0;
      host.rdone <= 1'b0;
      host.outen <= 1'b0;
    end else begin
      spi.start  <= 1'b0;
      host.rdone <= 1'b0;
      host.outen <= 1'b0;
      case (state)
        st_ready: begin
          if (host.rstart) begin
            // standard capacity cards take a byte address
            cmd_arg <= (card_type == card_sdhc) ? host.rsector
                                                : host.rsector << byte_index_w;
            state   <= st_cmd17;
          end
        end
        st_error: ;
        default: begin
          if (!pending) begin
            spi.start <= 1'b1;
            pending   <= 1'b1;
          end else if (spi.done) begin
            pending <= 1'b0;
            state   <= st_error;
            case (state)
              st_wake: state <= st_cmd0;
              st_cmd0:
                if (!spi.timeout && spi.r1 == 8'h01) state <= st_cmd8;
              st_cmd8:
                // idle and the check pattern echoed
                if (!spi.timeout && spi.r1 == 8'h01 && spi.resp[11:0] == sd_if_cond_arg[11:0])
                  state <= st_cmd55;
              st_cmd55:
                if (!spi.timeout && spi.r1[7:1] == 7'd0) state <= st_acmd41;
              st_acmd41: begin
                if (!spi.timeout && spi.r1 == 8'h00) state <= st_cmd58;
                else if (!spi.timeout && spi.r1 == 8'h01) state <= st_cmd55;
              end
              st_cmd58: begin
                if (!spi.timeout && spi.r1 == 8'h00) begin
                  // ccs bit of the ocr
                  card_type <= spi.resp[30] ? card_sdhc : card_sdv2;
                  state     <= st_ready;
                end
              end
              st_cmd17: begin
                if (!spi.timeout && spi.r1 == 8'h00) begin
                  cnt   <= '0;
                  state <= st_token;
                end
              end
              st_token: begin
                if (spi.rx_byte == sd_start_token) begin
                  cnt   <= '0;
                  state <= st_data;
                end else if (cnt != '1) begin
                  cnt   <= cnt + 1'b1;
                  state <= st_token;
                end
              end
              st_data: begin
                host.outen   <= 1'b1;
                host.outbyte <= spi.rx_byte;
                host.outaddr <= cnt;
                // wraps back to 0 after the last byte
                cnt          <= cnt + 1'b1;
                state        <= (cnt == byte_index_w'(sector_bytes - 1)) ? st_crc : st_data;
              end
              st_crc: begin
                // two crc16 bytes, dropped
                cnt <= cnt + 1'b1;
                if (cnt[0]) begin
                  host.rdone <= 1'b1;
                  state      <= st_ready;
                end else begin
                  state <= st_crc;
                end
              end
              default: state <= st_error;
            endcase
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/sd_spi_engine.sv
// spi mode engine
// sends 48-bit command frames with crc7, polls for r1, receives data bytes
`timescale 1ns/100ps
`default_nettype none

module sd_spi_engine #(
  parameter int unsigned clock_divider = 2
) (
  input  wire       clk,
  input  wire       rst_n,
  sd_spi_if.engine  ctrl,
  output wire       sd_clk,
  output wire       sd_mosi,
  input  wire       sd_miso
);
  import sd_proto_pkg::*;

  typedef enum logic [2:0] {
    ph_idle, ph_wake, ph_frame, ph_poll, ph_long, ph_rx
  } phase_e;

  phase_e      phase;
  spi_op_e     op_q;
  logic [47:0] tx_sr;
  logic [7:0]  rx_sr;
  logic [3:0]  bit_cnt;
  logic [4:0]  byte_cnt;
  logic        sclk_level;
  logic        rise;
  logic        fall;
  logic [39:0] frame_head;

  // crc7, polynomial x^7 + x^3 + 1, one bit per loop step msb first
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = data[i] ^ c[6];
      c  = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09;
    end
    return c;
  endfunction

  // start bit 0, transmission bit 1, index, argument
  assign frame_head = {2'b01, ctrl.index, ctrl.arg};

  sd_clk_gen #(.clock_divider(clock_divider)) i_clk_gen (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (phase != ph_idle),
    .sclk   (sclk_level),
    .rise   (rise),
    .fall   (fall)
  );

  assign sd_clk  = sclk_level;
  // ones are shifted in behind the frame so mosi idles high
  assign sd_mosi = tx_sr[47];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase     <= ph_idle;
      tx_sr     <= '1;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      ctrl.done <= 1'b0;
    end else begin
      ctrl.done <= 1'b0;
      if (phase == ph_idle) begin
        if (ctrl.start) begin
          op_q         <= ctrl.op;
          bit_cnt      <= '0;
          byte_cnt     <= '0;
          ctrl.timeout <= 1'b0;
          case (ctrl.op)
            op_wake: begin
              tx_sr <= '1;
              phase <= ph_wake;
            end
            op_rx_byte: begin
              tx_sr <= '1;
              phase <= ph_rx;
            end
            default: begin
              tx_sr <= {frame_head, crc7(frame_head), 1'b1};
              phase <= ph_frame;
            end
          endcase
        end
      end else if (rise) begin
        // miso sampled while sclk is high
        rx_sr   <= {rx_sr[6:0], sd_miso};
        bit_cnt <= bit_cnt + 1'b1;
      end else if (fall) begin
        // next bit goes out on every fall
        tx_sr <= {tx_sr[46:0], 1'b1};
        if (bit_cnt == 4'd8) begin
          // a whole byte has gone out and come in
          bit_cnt  <= '0;
          byte_cnt <= byte_cnt + 1'b1;
          case (phase)
            ph_wake: begin
              // 10 bytes give the 80 wake clocks
              if (byte_cnt == 5'd9) begin
                phase     <= ph_idle;
                ctrl.done <= 1'b1;
              end
            end
            ph_frame: begin
              if (byte_cnt == 5'd5) begin
                byte_cnt <= '0;
                phase    <= ph_poll;
              end
            end
            ph_poll: begin
              if (!rx_sr[7]) begin
                // r1 starts with a 0 bit
                ctrl.r1  <= rx_sr;
                byte_cnt <= '0;
                if (op_q == op_cmd_long) begin
                  phase <= ph_long;
                end else begin
                  phase     <= ph_idle;
                  ctrl.done <= 1'b1;
                end
              end else if (byte_cnt == 5'(resp_timeout_bytes - 1)) begin
                ctrl.timeout <= 1'b1;
                phase        <= ph_idle;
                ctrl.done    <= 1'b1;
              end
            end
            ph_long: begin
              // trailing 4 bytes, msb first
              ctrl.resp <= {ctrl.resp[23:0], rx_sr};
              if (byte_cnt == 5'd3) begin
                phase     <= ph_idle;
                ctrl.done <= 1'b1;
              end
            end
            default: begin
              ctrl.rx_byte <= rx_sr;
              phase        <= ph_idle;
              ctrl.done    <= 1'b1;
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sd_spi_if.sv
// spi engine control interface
// one operation per start, answered by exactly one done
`timescale 1ns/100ps
`default_nettype none

interface sd_spi_if;
  import sd_proto_pkg::*;

  // request side, only while the engine is idle
  logic        start;
  spi_op_e     op;
  sd_cmd_e     index;
  logic [31:0] arg;
  // result side, all valid with done
  logic        done;
  logic [7:0]  r1;
  logic [31:0] resp;
  logic [7:0]  rx_byte;
  logic        timeout;

  modport ctrl (output start, op, index, arg,
                input done, r1, resp, rx_byte, timeout);

  modport engine (input start, op, index, arg,
                  output done, r1, resp, rx_byte, timeout);

endinterface

`default_nettype wire

//--- src/sdcard.sv
// sd card sector reader, top level
// buffers one 512-byte sector and serves it a byte per command
`timescale 1ns/100ps
`default_nettype none

module sdcard #(
  parameter int unsigned clock_divider = 2
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire sd_host_pkg::host_cmd_e   command,
  input  wire [31:0]                    sector_address,
  output logic [7:0]                    data_out,
  output logic                          busy,
  output wire  [3:0]                    card_stat,
  output wire sd_host_pkg::card_type_e  card_type,
  output wire                           sd_clk,
  output wire                           sd_mosi,
  input  wire                           sd_miso
);
  import sd_host_pkg::*;

  typedef enum logic [1:0] {
    hs_init,
    hs_idle,
    hs_reading
  } host_state_e;

  host_state_e             state;
  logic [7:0]              buffer [sector_bytes];
  logic [byte_index_w-1:0] index;

  sd_read_if rd ();

  sd_reader #(.clock_divider(clock_divider)) i_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .host      (rd),
    .sd_clk    (sd_clk),
    .sd_mosi   (sd_mosi),
    .sd_miso   (sd_miso),
    .card_stat (card_stat),
    .card_type (card_type)
  );

  // byte under the index, no register in the path
  always_comb begin
    data_out = buffer[index];
  end

  // sector store, addressed by the stream itself
  always_ff @(posedge clk) begin
    if (rd.outen) buffer[rd.outaddr] <= rd.outbyte;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= hs_init;
      busy      <= 1'b1;
      index     <= '0;
      rd.rstart <= 1'b0;
    end else begin
      rd.rstart <= 1'b0;
      case (state)
        hs_init: begin
          // stays here for good if bring-up fails
          if (!rd.rbusy) begin
            busy  <= 1'b0;
            state <= hs_idle;
          end
        end
        hs_idle: begin
          if (command == cmd_read_sector) begin
            rd.rsector <= sector_address;
            rd.rstart  <= 1'b1;
            index      <= '0;
            busy       <= 1'b1;
            state      <= hs_reading;
          end else if (command == cmd_next_byte) begin
            index <= index + 1'b1;
          end
        end
        default: begin
          // follow the stream, wraps to 0 after byte 511
          if (rd.outen) index <= rd.outaddr + 1'b1;
          if (rd.rdone) begin
            busy  <= 1'b0;
            state <= hs_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verif/sd_card_model.sv
// behavioral sd card in spi mode
// checks command frames, answers bring-up and serves a sector pattern
`timescale 1ns/100ps
`default_nettype none

module sd_card_model (
  input  wire        sd_clk,
  input  wire        sd_mosi,
  output wire        sd_miso,
  input  wire        high_capacity,
  output wire [31:0] last_read_arg,
  output wire [31:0] read_count,
  output wire        frame_error
);

  logic [7:0]  rx_sh = 8'hFF;
  logic [2:0]  rx_bits = 3'd0;
  logic [47:0] frame = '0;
  int          frame_len = 0;
  logic [7:0]  tx_sh = 8'hFF;
  // bytes waiting to go out on miso
  logic [7:0]  tx_queue [$];
  logic        miso_q = 1'b1;
  logic        card_idle = 1'b1;
  // set after cmd55, the next command is an app command
  logic        app_next = 1'b0;
  int          acmd41_seen = 0;
  logic [31:0] arg_q = '0;
  logic [31:0] reads = '0;
  logic        err_q = 1'b0;

  assign sd_miso       = miso_q;
  assign last_read_arg = arg_q;
  assign read_count    = reads;
  assign frame_error   = err_q;

  // crc7 as the remainder of a long division by x^7 + x^3 + 1
  function automatic logic [6:0] crc7_by_division(input logic [39:0] msg);
    logic [46:0] rem;
    rem = {msg, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ 8'h89;
    end
    return rem[6:0];
  endfunction

  task automatic flag_value(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    $display("Fail %0t: %s is %0h, expected %0h", $time, name, got, expected);
    err_q = 1'b1;
  endtask

  // gap, start token, 512 pattern bytes, two crc16 bytes nobody checks
  task automatic queue_sector(input logic [31:0] block);
    logic [31:0] v;
    tx_queue.push_back(8'hFF);
    tx_queue.push_back(8'hFF);
    tx_queue.push_back(8'hFE);
    for (int i = 0; i < 512; i++) begin
      v = block * 32'd7 + 32'(i);
      tx_queue.push_back(v[7:0]);
    end
    tx_queue.push_back(8'hA5);
    tx_queue.push_back(8'h5A);
  endtask

  task automatic handle_frame();
    logic [5:0]  index;
    logic [31:0] arg;
    logic [31:0] ocr;
    index = frame[45:40];
    arg   = frame[39:8];
    // start bit is 0 by detection, transmission bit must follow as 1
    assert (frame[46]) else flag_value("transmission bit", 32'(frame[46]), 32'd1);
    assert (frame[7:1] == crc7_by_division(frame[47:8]))
      else flag_value("crc7", 32'(frame[7:1]), 32'(crc7_by_division(frame[47:8])));
    assert (frame[0]) else flag_value("end bit", 32'(frame[0]), 32'd1);
    // one ncr byte ahead of every response
    tx_queue.push_back(8'hFF);
    case (index)
      6'd0: begin
        // well known trailer of cmd0
        assert (frame[7:0] == 8'h95) else flag_value("cmd0 crc byte", 32'(frame[7:0]), 32'h95);
        card_idle   = 1'b1;
        acmd41_seen = 0;
        tx_queue.push_back(8'h01);
      end
      6'd8: begin
        assert (arg == 32'h0000_01AA) else flag_value("cmd8 argument", arg, 32'h1AA);
        assert (frame[7:0] == 8'h87) else flag_value("cmd8 crc byte", 32'(frame[7:0]), 32'h87);
        // r7, voltage and check pattern echoed
        tx_queue.push_back(8'h01);
        tx_queue.push_back(8'h00);
        tx_queue.push_back(8'h00);
        tx_queue.push_back({4'h0, arg[11:8]});
        tx_queue.push_back(arg[7:0]);
      end
      6'd55: tx_queue.push_back({7'd0, card_idle});
      6'd41: begin
        assert (app_next) else begin
          $display("Fail %0t: ACMD41 arrived without a CMD55 before it", $time);
          err_q = 1'b1;
        end
        // still initializing for the first two tries
        if (acmd41_seen < 2) begin
          acmd41_seen = acmd41_seen + 1;
          tx_queue.push_back(8'h01);
        end else begin
          card_idle = 1'b0;
          tx_queue.push_back(8'h00);
        end
      end
      6'd58: begin
        // power up done, ccs in bit 30
        ocr = high_capacity ? 32'hC0FF_8000 : 32'h80FF_8000;
        tx_queue.push_back(8'h00);
        tx_queue.push_back(ocr[31:24]);
        tx_queue.push_back(ocr[23:16]);
        tx_queue.push_back(ocr[15:8]);
        tx_queue.push_back(ocr[7:0]);
      end
      6'd17: begin
        arg_q = arg;
        reads = reads + 32'd1;
        tx_queue.push_back(8'h00);
        // byte address on standard capacity cards
        queue_sector(high_capacity ? arg : arg >> 9);
      end
      default: tx_queue.push_back(8'h04);
    endcase
    app_next = (index == 6'd55);
  endtask

  // mosi is sampled on the rising card clock
  always @(posedge sd_clk) begin
    rx_sh   = {rx_sh[6:0], sd_mosi};
    rx_bits = rx_bits + 3'd1;
    if (rx_bits == 3'd0) begin
      // a frame opens with a 0 start bit, idle bytes are all ones
      if (frame_len != 0 || !rx_sh[7]) begin
        frame     = {frame[39:0], rx_sh};
        frame_len = frame_len + 1;
        if (frame_len == 6) begin
          handle_frame();
          frame_len = 0;
        end
      end
    end
  end

  // miso moves on the falling card clock, a new byte at each byte boundary
  always @(negedge sd_clk) begin
    if (rx_bits == 3'd0) begin
      if (tx_queue.size() != 0) tx_sh = tx_queue.pop_front();
      else tx_sh = 8'hFF;
    end else begin
      tx_sh = {tx_sh[6:0], 1'b1};
    end
    miso_q = tx_sh[7];
  end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
// testbench clock and reset
// free running clk, rst_n held low for reset_cycles, again on each reset_req
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 2
) (
  input  wire  reset_req,
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset edges land on falling clk, away from the active edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    forever begin
      @(posedge reset_req);
      @(negedge clk);
      rst_n = 1'b0;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_sdcard.sv
// sd card reader testbench
// bring-up on sdhc and sdv2 cards, sector reads, index wrap and busy behavior
`timescale 1ns/100ps
`default_nettype none

module tb_sdcard;
  import sd_host_pkg::*;
  import sd_proto_pkg::*;

  localparam int clk_period_ns = 20;
  localparam int clock_divider = 1;
  localparam logic [31:0] seed = 32'd17547;
  // one card clock is two halves of 2**clock_divider clk cycles
  localparam int card_clk_ns = 2 * (2 ** clock_divider) * clk_period_ns;
  // worst case command, frame plus full poll plus 4 trailing bytes
  localparam int cmd_bits = 48 + 8 * resp_timeout_bytes + 32;
  // wake, cmd0, cmd8, three cmd55 and acmd41 pairs, cmd58
  localparam int bringup_bits = 80 + 9 * cmd_bits;
  // cmd17, a few token polls, data and crc16
  localparam int read_bits = cmd_bits + 8 * 8 + 8 * sector_bytes + 16;
  // two bring-ups and three reads, doubled
  localparam int watchdog_ns = 2 * (2 * bringup_bits + 3 * read_bits) * card_clk_ns;
  localparam int idle_wait_cycles = 2 * read_bits * card_clk_ns / clk_period_ns;

  wire         clk;
  wire         rst_n;
  logic        reset_req;
  host_cmd_e   command;
  logic [31:0] sector_address;
  wire  [7:0]  data_out;
  wire         busy;
  wire  [3:0]  card_stat;
  card_type_e  card_type;
  wire         sd_clk;
  wire         sd_mosi;
  wire         sd_miso;
  logic        high_capacity;
  wire  [31:0] last_read_arg;
  wire  [31:0] read_count;
  wire         model_error;
  logic [31:0] rng_state;

  tb_clock #(.period_ns(clk_period_ns)) i_clock (
    .reset_req (reset_req),
    .clk       (clk),
    .rst_n     (rst_n)
  );

  sdcard #(.clock_divider(clock_divider)) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .command        (command),
    .sector_address (sector_address),
    .data_out       (data_out),
    .busy           (busy),
    .card_stat      (card_stat),
    .card_type      (card_type),
    .sd_clk         (sd_clk),
    .sd_mosi        (sd_mosi),
    .sd_miso        (sd_miso)
  );

  sd_card_model i_card (
    .sd_clk        (sd_clk),
    .sd_mosi       (sd_mosi),
    .sd_miso       (sd_miso),
    .high_capacity (high_capacity),
    .last_read_arg (last_read_arg),
    .read_count    (read_count),
    .frame_error   (model_error)
  );

  task automatic end_in_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("Fail %0t: %s is %0h, expected %0h", $time, name, got, expected);
    end_in_failure();
  endtask

  task automatic report_problem(input string what);
    $display("%0t: %s", $time, what);
    end_in_failure();
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 22-bit sector so that a byte address still fits in 32 bits
  task automatic pick_sector(output logic [31:0] sector);
    rng_state = lcg_step(rng_state);
    sector    = {10'd0, rng_state[31:10]};
  endtask

  // pattern served by the card, low byte of block*7 + i
  function automatic logic [7:0] expected_byte(input logic [31:0] block, input int i);
    logic [31:0] v;
    v = block * 32'd7 + 32'(i);
    return v[7:0];
  endfunction

  task automatic step_byte();
    command = cmd_next_byte;
    @(negedge clk);
    command = cmd_idle;
  endtask

  task automatic start_read(input logic [31:0] sector);
    command        = cmd_read_sector;
    sector_address = sector;
    @(negedge clk);
    command = cmd_idle;
    assert (busy === 1'b1) else report_mismatch("busy", 32'(busy), 32'd1);
  endtask

  task automatic wait_until_idle();
    int waited;
    waited = 0;
    while (busy !== 1'b0) begin
      if (waited == idle_wait_cycles) begin
        report_problem("busy stayed high far longer than a read or bring-up takes");
      end else begin
        waited = waited + 1;
        @(negedge clk);
      end
    end
  endtask

  // walk all 512 bytes, then one more step must wrap to byte 0
  task automatic check_sector(input logic [31:0] block);
    for (int i = 0; i < sector_bytes; i++) begin
      if (i != 0) step_byte();
      assert (data_out == expected_byte(block, i))
        else report_mismatch($sformatf("data_out byte %0d", i), 32'(data_out),
                             32'(expected_byte(block, i)));
    end
    step_byte();
    assert (data_out == expected_byte(block, 0))
      else report_mismatch("data_out after wrap", 32'(data_out), 32'(expected_byte(block, 0)));
  endtask

  task automatic pulse_reset();
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    wait (rst_n === 1'b0);
    wait (rst_n === 1'b1);
    @(negedge clk);
  endtask

  // bring-up must never end in the error state
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      assert (card_stat != st_error)
        else report_problem("card_stat entered st_error");
    end
  end

  always @(posedge model_error) begin
    report_problem("card model rejected a command frame");
  end

  initial begin
    #(watchdog_ns);
    report_problem($sformatf("watchdog expired after %0d ns", watchdog_ns));
  end

  initial begin
    logic [31:0] sector;
    logic [31:0] other;
    logic [31:0] reads_before;
    command        = cmd_idle;
    sector_address = '0;
    high_capacity  = 1'b1;
    reset_req      = 1'b0;
    rng_state      = seed;
    wait (rst_n === 1'b1);
    @(negedge clk);

    // bring-up of an sdhc card
    assert (busy === 1'b1) else report_mismatch("busy", 32'(busy), 32'd1);
    wait_until_idle();
    assert (card_type == card_sdhc)
      else report_mismatch("card_type", 32'(card_type), 32'(card_sdhc));

    // one sector read, block addressed
    pick_sector(sector);
    reads_before = read_count;
    start_read(sector);
    wait_until_idle();
    assert (read_count == reads_before + 32'd1)
      else report_mismatch("read_count", read_count, reads_before + 32'd1);
    assert (last_read_arg == sector) else report_mismatch("cmd17 argument", last_read_arg, sector);
    check_sector(sector);

    // another read requested through the whole read, all of it dropped
    pick_sector(sector);
    pick_sector(other);
    reads_before = read_count;
    start_read(sector);
    command        = cmd_read_sector;
    sector_address = other;
    wait_until_idle();
    command = cmd_idle;
    check_sector(sector);
    // a stray cmd17 would have reached the card by now
    assert (read_count == reads_before + 32'd1)
      else report_mismatch("read_count", read_count, reads_before + 32'd1);
    assert (last_read_arg == sector) else report_mismatch("cmd17 argument", last_read_arg, sector);

    // reset again with a standard capacity card, byte addressed
    high_capacity = 1'b0;
    pulse_reset();
    assert (busy === 1'b1) else report_mismatch("busy", 32'(busy), 32'd1);
    wait_until_idle();
    assert (card_type == card_sdv2)
      else report_mismatch("card_type", 32'(card_type), 32'(card_sdv2));
    pick_sector(sector);
    start_read(sector);
    wait_until_idle();
    assert (last_read_arg == (sector << 9))
      else report_mismatch("cmd17 argument", last_read_arg, sector << 9);
    check_sector(sector);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/sd_host_pkg.sv
src/sd_proto_pkg.sv
src/sd_read_if.sv
src/sd_spi_if.sv
src/sd_clk_gen.sv
src/sd_spi_engine.sv
src/sd_reader.sv
src/sdcard.sv
verif/tb_clock.sv
verif/sd_card_model.sv
verif/tb_sdcard.sv
